// ==== sources.f ====
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/decExIf.sv
hdl/exResIf.sv
hdl/instrDecoder.sv
hdl/aluExecute.sv
hdl/resultStage.sv
hdl/mipsExecCore.sv
sim/tbMipsExecCore.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbMipsExecCore
FILELIST = sources.f
OBJDIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(TOOL) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== sim/tbMipsExecCore.sv ====
`timescale 1ns/1ps

module tbMipsExecCore;

        localparam int numInstr  = 2000;
        localparam int clkPeriod = 10;
        localparam int timeoutNs = (numInstr + 20) * clkPeriod + 500;

        typedef struct packed {
                logic            wr;
                logic            bad;
                isaPkg::regAddrT dest;
                logic [31:0]     data;
                logic [63:0]     acc;           // {hi,lo} after the instruction
        } expT;

        localparam logic [5:0] specialFns [0:16] = '{
                isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra, isaPkg::fnSllv,
                isaPkg::fnSrlv, isaPkg::fnSrav, isaPkg::fnMult, isaPkg::fnMultu,
                isaPkg::fnAdd, isaPkg::fnAddu, isaPkg::fnSub, isaPkg::fnAnd,
                isaPkg::fnOr, isaPkg::fnXor, isaPkg::fnNor, isaPkg::fnSlt,
                isaPkg::fnSltu
        };
        localparam logic [5:0] immOps [0:6] = '{
                isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu,
                isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori
        };
        localparam logic [5:0] special2Fns [0:2] = '{
                isaPkg::fnMadd, isaPkg::fnMul, isaPkg::fnMsub
        };

        logic          clk;
        logic          arstN;
        logic          inValid;
        isaPkg::instrT instr;
        logic [31:0]   rsData;
        logic [31:0]   rtData;
        logic          outValid;
        isaPkg::regAddrT outDest;
        logic [31:0]   outData;
        logic [31:0]   hi;
        logic [31:0]   lo;
        logic          badInstr;

        integer        seed;
        logic [63:0]   modelAcc;
        expT           expCur;                  // Newest, then a 2-stage delay line
        expT           expMid;
        expT           expOut;
        int            countReg;
        int            countHiLo;
        int            countBad;
        int            countNop;

        mipsExecCore #(.dataWidth(32)) mipsExecCore_inst (
                .clk      (clk),
                .arstN    (arstN),
                .inValid  (inValid),
                .instr    (instr),
                .rsData   (rsData),
                .rtData   (rtData),
                .outValid (outValid),
                .outDest  (outDest),
                .outData  (outData),
                .hi       (hi),
                .lo       (lo),
                .badInstr (badInstr)
        );

        initial clk = 1'b0;
        always #(clkPeriod / 2) clk = ~clk;

        //////////////////////////////////////////////////
        // Reference model
        //////////////////////////////////////////////////
        task automatic modelInstr(input isaPkg::instrT w, input logic [31:0] a,
                                  input logic [31:0] b, output expT e);
                logic [5:0]  op;
                logic [5:0]  fn;
                logic [4:0]  sa;
                logic [31:0] immS;
                logic [31:0] immZ;
                logic [63:0] prodS;
                logic [63:0] prodU;
                logic        isReg;
                logic        isBad;
                logic [31:0] res;

                op    = w[31:26];
                fn    = w[5:0];
                sa    = w[10:6];
                immS  = {{16{w[15]}}, w[15:0]};
                immZ  = {16'h0000, w[15:0]};
                prodS = 64'($signed(a)) * 64'($signed(b));
                prodU = 64'(a) * 64'(b);
                isReg = 1'b1;
                isBad = 1'b0;
                res   = '0;
                e     = '0;
                if (w == '0) begin
                        isReg = 1'b0;                   // NOP
                        countNop++;
                end else if (op == isaPkg::opSpecial) begin
                        e.dest = w[15:11];
                        case (fn)
                                isaPkg::fnSll:  res = b << sa;
                                isaPkg::fnSrl:  res = b >> sa;
                                isaPkg::fnSra:  res = $signed(b) >>> sa;
                                isaPkg::fnSllv: res = b << a[4:0];
                                isaPkg::fnSrlv: res = b >> a[4:0];
                                isaPkg::fnSrav: res = $signed(b) >>> a[4:0];
                                isaPkg::fnAdd, isaPkg::fnAddu: res = a + b;
                                isaPkg::fnSub:  res = a - b;
                                isaPkg::fnAnd:  res = a & b;
                                isaPkg::fnOr:   res = a | b;
                                isaPkg::fnXor:  res = a ^ b;
                                isaPkg::fnNor:  res = ~(a | b);
                                isaPkg::fnSlt:  res = {31'b0, $signed(a) < $signed(b)};
                                isaPkg::fnSltu: res = {31'b0, a < b};
                                isaPkg::fnMult: begin
                                        isReg    = 1'b0;
                                        modelAcc = prodS;
                                        countHiLo++;
                                end
                                isaPkg::fnMultu: begin
                                        isReg    = 1'b0;
                                        modelAcc = prodU;
                                        countHiLo++;
                                end
                                default: isBad = 1'b1;
                        endcase
                end else if (op == isaPkg::opSpecial2) begin
                        e.dest = w[15:11];
                        case (fn)
                                isaPkg::fnMul: res = prodS[31:0];
                                isaPkg::fnMadd: begin
                                        isReg    = 1'b0;
                                        modelAcc = modelAcc + prodS;
                                        countHiLo++;
                                end
                                isaPkg::fnMsub: begin
                                        isReg    = 1'b0;
                                        modelAcc = modelAcc - prodS;
                                        countHiLo++;
                                end
                                default: isBad = 1'b1;
                        endcase
                end else begin
                        e.dest = w[20:16];              // I-type writes rt
                        case (op)
                                isaPkg::opAddi, isaPkg::opAddiu: res = a + immS;
                                isaPkg::opSlti:  res = {31'b0, $signed(a) < $signed(immS)};
                                isaPkg::opSltiu: res = {31'b0, a < immS};
                                isaPkg::opAndi:  res = a & immZ;
                                isaPkg::opOri:   res = a | immZ;
                                isaPkg::opXori:  res = a ^ immZ;
                                default:         isBad = 1'b1;
                        endcase
                end
                if (isBad) begin
                        isReg = 1'b0;
                        countBad++;
                end
                if (isReg)
                        countReg++;
                e.wr   = isReg;
                e.bad  = isBad;
                e.data = res;
                e.acc  = modelAcc;
        endtask

        task automatic pushExpect(input expT e);
                expOut <= expMid;
                expMid <= expCur;
                expCur <= e;
        endtask

        task automatic driveIdle();
                expT e;

                inValid = 1'b0;
                e       = '0;
                e.acc   = modelAcc;
                pushExpect(e);
        endtask

        task automatic driveNext();
                isaPkg::instrT w;
                logic [31:0]   a;
                logic [31:0]   b;
                logic [4:0]    sa;
                int            pick;
                expT           e;

                w    = $random(seed);
                a    = $random(seed);
                b    = $random(seed);
                pick = {$random(seed)} % 16;
                case ({$random(seed)} % 4)
                        0:       sa = 5'd0;
                        1:       sa = 5'd31;
                        default: sa = w[10:6];
                endcase
                if (pick < 7) begin
                        w[31:26] = isaPkg::opSpecial;
                        w[5:0]   = specialFns[5'({$random(seed)} % 17)];
                        w[10:6]  = sa;
                        a[4:0]   = sa;                  // Same corners for variable shifts
                end else if (pick < 11) begin
                        w[31:26] = immOps[3'({$random(seed)} % 7)];
                end else if (pick < 13) begin
                        w[31:26] = isaPkg::opSpecial2;
                        w[5:0]   = special2Fns[2'({$random(seed)} % 3)];
                end else if (pick == 13) begin
                        w = '0;
                end
                // Raw random word otherwise, nearly always illegal
                inValid = ({$random(seed)} % 4) != 0;
                instr   = w;
                rsData  = a;
                rtData  = b;
                e       = '0;
                e.acc   = modelAcc;
                if (inValid)
                        modelInstr(w, a, b, e);
                pushExpect(e);
        endtask

        task automatic reportMismatch(input string msg);
                $display("ERROR at %0t: %s", $time, msg);
                $display("TEST FAILED");
                $fatal(1, "Simulation stopped at the first mismatch");
        endtask

        //////////////////////////////////////////////////
        // Checks against the delayed expectation
        //////////////////////////////////////////////////
        validCheck: assert property (@(negedge clk) outValid == expOut.wr)
                else reportMismatch("outValid differs from the model");
        dataCheck: assert property (@(negedge clk)
                expOut.wr |-> outDest == expOut.dest && outData == expOut.data)
                else reportMismatch("write-back destination or data differs from the model");
        badCheck: assert property (@(negedge clk) badInstr == expOut.bad)
                else reportMismatch("badInstr differs from the model");
        accCheck: assert property (@(negedge clk) {hi, lo} == expOut.acc)
                else reportMismatch("hi/lo differ from the model");
        resetCheck: assert property (@(negedge clk)
                !arstN |-> !outValid && !badInstr && hi == '0 && lo == '0)
                else reportMismatch("outputs not cleared during reset");

        initial begin
                #(timeoutNs);
                $display("TEST FAILED");
                $fatal(1, "Watchdog expired before the run completed");
        end

        initial begin
                seed      = 32'h8c2b4067;
                arstN     = 1'b0;
                inValid   = 1'b0;
                instr     = '0;
                rsData    = '0;
                rtData    = '0;
                modelAcc  = '0;
                expCur    = '0;
                expMid    = '0;
                expOut    = '0;
                countReg  = 0;
                countHiLo = 0;
                countBad  = 0;
                countNop  = 0;
                repeat (10) begin
                        @(negedge clk);
                        driveIdle();
                end
                arstN = 1'b1;
                for (int i = 0; i < numInstr; i++) begin
                        @(negedge clk);
                        driveNext();
                end
                repeat (5) begin                        // Drain the pipeline
                        @(negedge clk);
                        driveIdle();
                end
                if (countReg == 0 || countHiLo == 0 || countBad == 0 || countNop == 0) begin
                        $display("TEST FAILED");
                        $fatal(1, "Stimulus never reached one of the checked outcomes");
                end else begin
                        $display("TEST OK");
                        $finish;
                end
        end

endmodule

// ==== hdl/mipsExecCore.sv ====
`timescale 1ns/1ps

module mipsExecCore #(
        parameter int dataWidth = 32
) (
        input  logic                 clk,
        input  logic                 arstN,
        input  logic                 inValid,
        input  isaPkg::instrT        instr,
        input  logic [dataWidth-1:0] rsData,
        input  logic [dataWidth-1:0] rtData,
        output logic                 outValid,
        output isaPkg::regAddrT      outDest,
        output logic [dataWidth-1:0] outData,
        output logic [dataWidth-1:0] hi,
        output logic [dataWidth-1:0] lo,
        output logic                 badInstr
);

        decExIf #(.dataWidth(dataWidth)) decEx ();
        exResIf #(.dataWidth(dataWidth)) exRes ();

        instrDecoder #(.dataWidth(dataWidth)) instrDecoder_inst (
                .clk     (clk),
                .arstN   (arstN),
                .inValid (inValid),
                .instr   (instr),
                .rsData  (rsData),
                .rtData  (rtData),
                .decOut  (decEx.dec)
        );

        aluExecute #(.dataWidth(dataWidth)) aluExecute_inst (
                .clk   (clk),
                .arstN (arstN),
                .exIn  (decEx.ex),
                .exOut (exRes.ex)
        );

        resultStage #(.dataWidth(dataWidth)) resultStage_inst (
                .clk      (clk),
                .arstN    (arstN),
                .resIn    (exRes.res),
                .outValid (outValid),
                .badInstr (badInstr),
                .outDest  (outDest),
                .outData  (outData),
                .hi       (hi),
                .lo       (lo)
        );

endmodule

// ==== hdl/resultStage.sv ====
`timescale 1ns/1ps

module resultStage #(
        parameter int dataWidth = 32
) (
        input  logic                 clk,
        input  logic                 arstN,
        exResIf.res                  resIn,
        output logic                 outValid,
        output logic                 badInstr,
        output isaPkg::regAddrT      outDest,
        output logic [dataWidth-1:0] outData,
        output logic [dataWidth-1:0] hi,
        output logic [dataWidth-1:0] lo
);

        logic                   isReg;
        logic                   isHiLo;
        logic                   isIllegal;
        logic [2*dataWidth-1:0] acc;
        logic [2*dataWidth-1:0] accNext;

        assign isReg     = resIn.valid && resIn.kind == ctrlPkg::resReg;
        assign isHiLo    = resIn.valid && resIn.kind == ctrlPkg::resHiLo;
        assign isIllegal = resIn.valid && resIn.kind == ctrlPkg::resIllegal;

        always_comb begin
                case (resIn.hiLoOp)
                        ctrlPkg::hiLoMove: accNext = resIn.product;
                        ctrlPkg::hiLoAdd:  accNext = acc + resIn.product;  // Wraps at 2W
                        ctrlPkg::hiLoSub:  accNext = acc - resIn.product;
                        default:           accNext = acc;
                endcase
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        outValid <= 1'b0;
                        badInstr <= 1'b0;
                        acc      <= '0;
                end else begin
                        outValid <= isReg;
                        badInstr <= isIllegal;
                        if (isHiLo)
                                acc <= accNext;
                end
        end

        always_ff @(posedge clk) begin
                if (isReg) begin
                        outDest <= resIn.dest;
                        outData <= resIn.result;
                end
        end

        assign hi = acc[2*dataWidth-1:dataWidth];
        assign lo = acc[dataWidth-1:0];

        // Accumulator kind must carry a real Hi/Lo operation
        hiLoOpSet: assert property (@(posedge clk) disable iff (!arstN)
                isHiLo |-> resIn.hiLoOp != ctrlPkg::hiLoNone);

endmodule

// ==== hdl/aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute #(
        parameter int dataWidth = 32
) (
        input  logic clk,
        input  logic arstN,
        decExIf.ex   exIn,
        exResIf.ex   exOut
);

        logic [4:0]             shAmt;
        logic                   signedMul;
        logic [2*dataWidth-1:0] mulA;
        logic [2*dataWidth-1:0] mulB;
        logic [2*dataWidth-1:0] product;
        logic [dataWidth-1:0]   aluRes;

        assign shAmt = exIn.operandA[4:0];

        //////////////////////////////////////////////////
        // Multiplier
        //////////////////////////////////////////////////
        assign signedMul = exIn.aluOp != ctrlPkg::aluMulu;
        assign mulA      = {{dataWidth{signedMul & exIn.operandA[dataWidth-1]}}, exIn.operandA};
        assign mulB      = {{dataWidth{signedMul & exIn.operandB[dataWidth-1]}}, exIn.operandB};
        assign product   = mulA * mulB;         // Low 2W bits are exact

        //////////////////////////////////////////////////
        // ALU and shifter
        //////////////////////////////////////////////////
        always_comb begin
                case (exIn.aluOp)
                        ctrlPkg::aluAdd: aluRes = exIn.operandA + exIn.operandB;
                        ctrlPkg::aluSub: aluRes = exIn.operandA - exIn.operandB;
                        ctrlPkg::aluAnd: aluRes = exIn.operandA & exIn.operandB;
                        ctrlPkg::aluOr:  aluRes = exIn.operandA | exIn.operandB;
                        ctrlPkg::aluXor: aluRes = exIn.operandA ^ exIn.operandB;
                        ctrlPkg::aluNor: aluRes = ~(exIn.operandA | exIn.operandB);
                        ctrlPkg::aluSlt:
                                aluRes = {{(dataWidth-1){1'b0}},
                                          $signed(exIn.operandA) < $signed(exIn.operandB)};
                        ctrlPkg::aluSltu:
                                aluRes = {{(dataWidth-1){1'b0}}, exIn.operandA < exIn.operandB};
                        ctrlPkg::aluSll: aluRes = exIn.operandB << shAmt;
                        ctrlPkg::aluSrl: aluRes = exIn.operandB >> shAmt;
                        ctrlPkg::aluSra: aluRes = $unsigned($signed(exIn.operandB) >>> shAmt);
                        ctrlPkg::aluMul, ctrlPkg::aluMulu:
                                aluRes = product[dataWidth-1:0];    // MUL result
                        default: aluRes = '0;
                endcase
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN)
                        exOut.valid <= 1'b0;
                else
                        exOut.valid <= exIn.valid;
        end

        always_ff @(posedge clk) begin
                exOut.kind    <= exIn.kind;
                exOut.hiLoOp  <= exIn.hiLoOp;
                exOut.dest    <= exIn.dest;
                exOut.result  <= aluRes;
                exOut.product <= product;
        end

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder #(
        parameter int dataWidth = 32
) (
        input  logic                 clk,
        input  logic                 arstN,
        input  logic                 inValid,
        input  isaPkg::instrT        instr,
        input  logic [dataWidth-1:0] rsData,
        input  logic [dataWidth-1:0] rtData,
        decExIf.dec                  decOut
);

        logic [5:0]                   opcode;
        logic [5:0]                   funct;
        logic [4:0]                   shamt;
        logic [isaPkg::immWidth-1:0]  imm;
        isaPkg::regAddrT              rtAddr;
        isaPkg::regAddrT              rdAddr;
        logic                         immSel;
        logic                         zeroExt;
        logic                         shiftImm;
        logic [dataWidth-1:0]         immExt;
        ctrlPkg::resKindT             kindNext;
        ctrlPkg::aluOpT               aluNext;
        ctrlPkg::hiLoOpT              hiLoNext;

        assign opcode = instr[isaPkg::opLsb +: 6];
        assign funct  = instr[isaPkg::fnLsb +: 6];
        assign shamt  = instr[isaPkg::shamtLsb +: 5];
        assign imm    = instr[0 +: isaPkg::immWidth];
        assign rtAddr = instr[isaPkg::rtLsb +: 5];
        assign rdAddr = instr[isaPkg::rdLsb +: 5];

        assign immSel   = !(opcode inside {isaPkg::opSpecial, isaPkg::opSpecial2});
        assign zeroExt  = opcode inside {isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori};
        assign shiftImm = (opcode == isaPkg::opSpecial) &&
                          (funct inside {isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra});
        assign immExt   = {{(dataWidth-isaPkg::immWidth){imm[15] & ~zeroExt}}, imm};

        //////////////////////////////////////////////////
        // Opcode and function decode
        //////////////////////////////////////////////////
        always_comb begin
                kindNext = ctrlPkg::resReg;
                aluNext  = ctrlPkg::aluAdd;
                hiLoNext = ctrlPkg::hiLoNone;
                case (opcode)
                        isaPkg::opSpecial: begin
                                case (funct)
                                        isaPkg::fnSll, isaPkg::fnSllv: aluNext = ctrlPkg::aluSll;
                                        isaPkg::fnSrl, isaPkg::fnSrlv: aluNext = ctrlPkg::aluSrl;
                                        isaPkg::fnSra, isaPkg::fnSrav: aluNext = ctrlPkg::aluSra;
                                        isaPkg::fnAdd, isaPkg::fnAddu: aluNext = ctrlPkg::aluAdd;
                                        isaPkg::fnSub:  aluNext = ctrlPkg::aluSub;
                                        isaPkg::fnAnd:  aluNext = ctrlPkg::aluAnd;
                                        isaPkg::fnOr:   aluNext = ctrlPkg::aluOr;
                                        isaPkg::fnXor:  aluNext = ctrlPkg::aluXor;
                                        isaPkg::fnNor:  aluNext = ctrlPkg::aluNor;
                                        isaPkg::fnSlt:  aluNext = ctrlPkg::aluSlt;
                                        isaPkg::fnSltu: aluNext = ctrlPkg::aluSltu;
                                        isaPkg::fnMult: begin
                                                kindNext = ctrlPkg::resHiLo;
                                                aluNext  = ctrlPkg::aluMul;
                                                hiLoNext = ctrlPkg::hiLoMove;
                                        end
                                        isaPkg::fnMultu: begin
                                                kindNext = ctrlPkg::resHiLo;
                                                aluNext  = ctrlPkg::aluMulu;
                                                hiLoNext = ctrlPkg::hiLoMove;
                                        end
                                        default: kindNext = ctrlPkg::resIllegal;
                                endcase
                        end
                        isaPkg::opSpecial2: begin
                                aluNext = ctrlPkg::aluMul;
                                case (funct)
                                        isaPkg::fnMul: kindNext = ctrlPkg::resReg;
                                        isaPkg::fnMadd: begin
                                                kindNext = ctrlPkg::resHiLo;
                                                hiLoNext = ctrlPkg::hiLoAdd;
                                        end
                                        isaPkg::fnMsub: begin
                                                kindNext = ctrlPkg::resHiLo;
                                                hiLoNext = ctrlPkg::hiLoSub;
                                        end
                                        default: kindNext = ctrlPkg::resIllegal;
                                endcase
                        end
                        isaPkg::opAddi, isaPkg::opAddiu: aluNext = ctrlPkg::aluAdd;
                        isaPkg::opSlti:  aluNext = ctrlPkg::aluSlt;
                        isaPkg::opSltiu: aluNext = ctrlPkg::aluSltu;
                        isaPkg::opAndi:  aluNext = ctrlPkg::aluAnd;
                        isaPkg::opOri:   aluNext = ctrlPkg::aluOr;
                        isaPkg::opXori:  aluNext = ctrlPkg::aluXor;
                        default:         kindNext = ctrlPkg::resIllegal;
                endcase
                if (instr == '0)
                        kindNext = ctrlPkg::resNone;        // NOP only
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN)
                        decOut.valid <= 1'b0;
                else
                        decOut.valid <= inValid;
        end

        always_ff @(posedge clk) begin
                decOut.kind     <= kindNext;
                decOut.aluOp    <= aluNext;
                decOut.hiLoOp   <= hiLoNext;
                decOut.dest     <= immSel ? rtAddr : rdAddr;
                decOut.operandA <= shiftImm ? {{(dataWidth-5){1'b0}}, shamt} : rsData;
                decOut.operandB <= immSel ? immExt : rtData;
        end

        aluOpKnown: assert property (@(posedge clk) disable iff (!arstN)
                decOut.valid |-> !$isunknown(decOut.aluOp));

endmodule

// ==== hdl/exResIf.sv ====
`timescale 1ns/1ps

interface exResIf #(
        parameter int dataWidth = 32
);

        logic                   valid;
        ctrlPkg::resKindT       kind;
        ctrlPkg::hiLoOpT        hiLoOp;
        isaPkg::regAddrT        dest;
        logic [dataWidth-1:0]   result;
        logic [2*dataWidth-1:0] product;    // Full {hi,lo} width

        modport ex(output valid, kind, hiLoOp, dest, result, product);
        modport res(input valid, kind, hiLoOp, dest, result, product);

endinterface

// ==== hdl/decExIf.sv ====
`timescale 1ns/1ps

interface decExIf #(
        parameter int dataWidth = 32
);

        logic                 valid;
        ctrlPkg::resKindT     kind;
        ctrlPkg::aluOpT       aluOp;
        ctrlPkg::hiLoOpT      hiLoOp;
        isaPkg::regAddrT      dest;
        logic [dataWidth-1:0] operandA;     // Shift amount for shifts
        logic [dataWidth-1:0] operandB;

        modport dec(output valid, kind, aluOp, hiLoOp, dest, operandA, operandB);
        modport ex(input valid, kind, aluOp, hiLoOp, dest, operandA, operandB);

endinterface

// ==== hdl/ctrlPkg.sv ====
package ctrlPkg;

        typedef enum logic [3:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluXor,
                aluNor,
                aluSlt,
                aluSltu,
                aluSll,
                aluSrl,
                aluSra,
                aluMul,         // Signed product
                aluMulu         // Unsigned product
        } aluOpT;

        typedef enum logic [1:0] {
                hiLoNone,
                hiLoMove,
                hiLoAdd,
                hiLoSub
        } hiLoOpT;

        typedef enum logic [1:0] {
                resNone,
                resReg,
                resHiLo,
                resIllegal
        } resKindT;

endpackage

// ==== hdl/isaPkg.sv ====
package isaPkg;

        typedef logic [31:0] instrT;
        typedef logic [4:0]  regAddrT;

        // Field positions in the instruction word
        localparam int opLsb    = 26;
        localparam int rtLsb    = 16;
        localparam int rdLsb    = 11;
        localparam int shamtLsb = 6;
        localparam int fnLsb    = 0;
        localparam int immWidth = 16;

        localparam logic [5:0] opSpecial  = 6'b000000;
        localparam logic [5:0] opSpecial2 = 6'b011100;
        localparam logic [5:0] opAddi     = 6'b001000;
        localparam logic [5:0] opAddiu    = 6'b001001;
        localparam logic [5:0] opSlti     = 6'b001010;
        localparam logic [5:0] opSltiu    = 6'b001011;
        localparam logic [5:0] opAndi     = 6'b001100;
        localparam logic [5:0] opOri      = 6'b001101;
        localparam logic [5:0] opXori     = 6'b001110;

        localparam logic [5:0] fnSll   = 6'b000000;
        localparam logic [5:0] fnSrl   = 6'b000010;
        localparam logic [5:0] fnSra   = 6'b000011;
        localparam logic [5:0] fnSllv  = 6'b000100;
        localparam logic [5:0] fnSrlv  = 6'b000110;
        localparam logic [5:0] fnSrav  = 6'b000111;
        localparam logic [5:0] fnMult  = 6'b011000;
        localparam logic [5:0] fnMultu = 6'b011001;
        localparam logic [5:0] fnAdd   = 6'b100000;
        localparam logic [5:0] fnAddu  = 6'b100001;
        localparam logic [5:0] fnSub   = 6'b100010;
        localparam logic [5:0] fnAnd   = 6'b100100;
        localparam logic [5:0] fnOr    = 6'b100101;
        localparam logic [5:0] fnXor   = 6'b100110;
        localparam logic [5:0] fnNor   = 6'b100111;
        localparam logic [5:0] fnSlt   = 6'b101010;
        localparam logic [5:0] fnSltu  = 6'b101011;

        // SPECIAL2 function codes
        localparam logic [5:0] fnMadd = 6'b000000;
        localparam logic [5:0] fnMul  = 6'b000010;
        localparam logic [5:0] fnMsub = 6'b000100;

endpackage
